// ==== verilog/aipBusPkg.sv ====
`default_nettype none

package aipBusPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] configCode_t;

  // Host config codes
  localparam configCode_t CfgMemInData  = 5'd0;
  localparam configCode_t CfgMemInPtr   = 5'd1;
  localparam configCode_t CfgMemOutData = 5'd2;
  localparam configCode_t CfgMemOutPtr  = 5'd3;
  localparam configCode_t CfgConfData   = 5'd4;
  localparam configCode_t CfgConfPtr    = 5'd5;
  localparam configCode_t CfgStatus     = 5'd30;
  localparam configCode_t CfgId         = 5'd31;

  localparam word_t IpId = 32'h0000_200F;

  // Status word bit positions
  localparam int StatIntEnBit = 8;
  localparam int StatPendBit  = 16;

  // One host bus cycle, strobes are single cycle
  typedef struct packed {
    configCode_t code;
    logic        read;
    logic        write;
    logic        start;
    word_t       data;
  } hostCmd_t;

endpackage

`default_nettype wire

// ==== verilog/ipCorePkg.sv ====
`default_nettype none

package ipCorePkg;

  typedef logic [15:0] memAddr_t; // Widest memory address

  // Flags reported by the core
  typedef struct packed {
    logic busy;
    logic readMem;
    logic writeMem;
    logic trap;
  } coreStatus_t;

  // Core read port into the input memory
  typedef struct packed {
    memAddr_t addr;
  } memRd_t;

  // Core write port into the output memory
  typedef struct packed {
    logic              wrEn;
    memAddr_t          addr;
    aipBusPkg::word_t  data;
  } memWr_t;

endpackage

`default_nettype wire

// ==== verilog/dualPortRam.sv ====
`default_nettype none

module dualPortRam #(
  parameter int AddrWidth = 8
) (
  input  wire                         clk,
  input  wire                         wrEn_i,
  input  wire logic [AddrWidth-1:0]   wrAddr_i,
  input  wire aipBusPkg::word_t       wrData_i,
  input  wire logic [AddrWidth-1:0]   rdAddr_i,
  output aipBusPkg::word_t            rdData_o
);

  localparam int Depth = 2 ** AddrWidth;

  aipBusPkg::word_t mem [Depth];

  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      mem[wrAddr_i] <= wrData_i;
    end
    rdData_o <= mem[rdAddr_i]; // One cycle read latency
  end

endmodule

`default_nettype wire

// ==== verilog/aipControl.sv ====
`default_nettype none

module aipControl (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       en_i,
  input  wire aipBusPkg::hostCmd_t  hostCmd_i,
  input  wire aipBusPkg::word_t     memOutRdData_i,
  input  wire aipBusPkg::word_t     statusWord_i,
  output logic                      memInWrEn_o,
  output ipCorePkg::memAddr_t       memInWrAddr_o,
  output ipCorePkg::memAddr_t       memOutRdAddr_o,
  output aipBusPkg::word_t          hostData_o
);

  logic memInDataWr;
  logic memInPtrWr;
  logic memOutDataRd;
  logic memOutPtrWr;

  ipCorePkg::memAddr_t ptrLoad;
  ipCorePkg::memAddr_t memInPtr;
  ipCorePkg::memAddr_t memOutPtr;

  // Strobe decode
  assign memInDataWr  = hostCmd_i.write && (hostCmd_i.code == aipBusPkg::CfgMemInData);
  assign memInPtrWr   = hostCmd_i.write && (hostCmd_i.code == aipBusPkg::CfgMemInPtr);
  assign memOutDataRd = hostCmd_i.read && (hostCmd_i.code == aipBusPkg::CfgMemOutData);
  assign memOutPtrWr  = hostCmd_i.write && (hostCmd_i.code == aipBusPkg::CfgMemOutPtr);

  assign ptrLoad = ipCorePkg::memAddr_t'(hostCmd_i.data); // Low bits of the data word

  // Input memory write pointer
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      memInPtr <= '0;
    end else if (en_i) begin
      if (memInPtrWr) begin
        memInPtr <= ptrLoad;
      end else if (memInDataWr) begin
        memInPtr <= memInPtr + 1'b1;
      end
    end
  end

  // Output memory read pointer
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      memOutPtr <= '0;
    end else if (en_i) begin
      if (memOutPtrWr) begin
        memOutPtr <= ptrLoad;
      end else if (memOutDataRd) begin
        memOutPtr <= memOutPtr + 1'b1;
      end
    end
  end

  assign memInWrEn_o    = memInDataWr; // Not gated by en_i
  assign memInWrAddr_o  = memInPtr;
  assign memOutRdAddr_o = memOutPtr;

  // Host readback select
  always_comb begin
    case (hostCmd_i.code)
      aipBusPkg::CfgMemOutData: hostData_o = memOutRdData_i;
      aipBusPkg::CfgStatus:     hostData_o = statusWord_i;
      default:                  hostData_o = aipBusPkg::IpId; // Id and unmapped codes
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/aipConfigRegs.sv ====
`default_nettype none

module aipConfigRegs #(
  parameter int ConfRegCount = 4
) (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire                                   en_i,
  input  wire aipBusPkg::hostCmd_t              hostCmd_i,
  output aipBusPkg::word_t [ConfRegCount-1:0]   confRegs_o
);

  localparam int PtrWidth = (ConfRegCount > 1) ? $clog2(ConfRegCount) : 1;

  typedef logic [PtrWidth-1:0] confPtr_t;

  localparam confPtr_t LastReg = confPtr_t'(ConfRegCount - 1);

  logic     dataWr;
  logic     ptrWr;
  confPtr_t wrPtr;

  assign dataWr = hostCmd_i.write && (hostCmd_i.code == aipBusPkg::CfgConfData);
  assign ptrWr  = hostCmd_i.write && (hostCmd_i.code == aipBusPkg::CfgConfPtr);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wrPtr      <= '0;
      confRegs_o <= '0;
    end else begin
      if (dataWr) begin
        confRegs_o[wrPtr] <= hostCmd_i.data;
      end
      if (en_i) begin
        if (ptrWr) begin
          wrPtr <= confPtr_t'(hostCmd_i.data % ConfRegCount);
        end else if (dataWr) begin
          wrPtr <= (wrPtr == LastReg) ? '0 : wrPtr + 1'b1; // Wrap after last register
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/aipStatusReg.sv ====
`default_nettype none

module aipStatusReg (
  input  wire                         clk,
  input  wire                         rst,
  input  wire aipBusPkg::hostCmd_t    hostCmd_i,
  input  wire ipCorePkg::coreStatus_t coreStatus_i,
  input  wire                         coreDone_i,
  output aipBusPkg::word_t            statusWord_o,
  output logic                        irq_o
);

  logic statusWr;
  logic intEn;
  logic pending;

  assign statusWr = hostCmd_i.write && (hostCmd_i.code == aipBusPkg::CfgStatus);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      intEn   <= 1'b0;
      pending <= 1'b0;
    end else begin
      if (statusWr) begin
        intEn <= hostCmd_i.data[aipBusPkg::StatIntEnBit];
      end
      // Done wins over a clear in the same cycle
      if (coreDone_i) begin
        pending <= 1'b1;
      end else if (statusWr && hostCmd_i.data[aipBusPkg::StatPendBit]) begin
        pending <= 1'b0;
      end
    end
  end

  always_comb begin
    statusWord_o      = '0;
    statusWord_o[3:0] = {coreStatus_i.trap, coreStatus_i.writeMem,
                         coreStatus_i.readMem, coreStatus_i.busy};
    statusWord_o[aipBusPkg::StatIntEnBit] = intEn;
    statusWord_o[aipBusPkg::StatPendBit]  = pending;
  end

  assign irq_o = pending & intEn;

endmodule

`default_nettype wire

// ==== verilog/aipWrapper.sv ====
`default_nettype none

module aipWrapper #(
  parameter int MemInAddrWidth  = 11,
  parameter int MemOutAddrWidth = 9,
  parameter int ConfRegCount    = 4
) (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire                                   en_i,
  input  wire aipBusPkg::hostCmd_t              hostCmd_i,
  input  wire ipCorePkg::memRd_t                memRd_i,
  input  wire ipCorePkg::memWr_t                memWr_i,
  input  wire ipCorePkg::coreStatus_t           coreStatus_i,
  input  wire                                   coreDone_i,
  output aipBusPkg::word_t                      hostData_o,
  output logic                                  irq_o,
  output logic                                  start_o,
  output aipBusPkg::word_t                      memInData_o,
  output aipBusPkg::word_t [ConfRegCount-1:0]   confRegs_o
);

  logic                memInWrEn;
  ipCorePkg::memAddr_t memInWrAddr;
  ipCorePkg::memAddr_t memOutRdAddr;
  aipBusPkg::word_t    memOutRdData;
  aipBusPkg::word_t    statusWord;

  assign start_o = hostCmd_i.start;

  aipControl control (
    .clk            (clk),
    .rst            (rst),
    .en_i           (en_i),
    .hostCmd_i      (hostCmd_i),
    .memOutRdData_i (memOutRdData),
    .statusWord_i   (statusWord),
    .memInWrEn_o    (memInWrEn),
    .memInWrAddr_o  (memInWrAddr),
    .memOutRdAddr_o (memOutRdAddr),
    .hostData_o     (hostData_o)
  );

  // Host fills, core reads
  dualPortRam #(.AddrWidth(MemInAddrWidth)) memIn (
    .clk      (clk),
    .wrEn_i   (memInWrEn),
    .wrAddr_i (memInWrAddr[MemInAddrWidth-1:0]),
    .wrData_i (hostCmd_i.data),
    .rdAddr_i (memRd_i.addr[MemInAddrWidth-1:0]),
    .rdData_o (memInData_o)
  );

  // Core fills, host drains
  dualPortRam #(.AddrWidth(MemOutAddrWidth)) memOut (
    .clk      (clk),
    .wrEn_i   (memWr_i.wrEn),
    .wrAddr_i (memWr_i.addr[MemOutAddrWidth-1:0]),
    .wrData_i (memWr_i.data),
    .rdAddr_i (memOutRdAddr[MemOutAddrWidth-1:0]),
    .rdData_o (memOutRdData)
  );

  aipConfigRegs #(.ConfRegCount(ConfRegCount)) configRegs (
    .clk        (clk),
    .rst        (rst),
    .en_i       (en_i),
    .hostCmd_i  (hostCmd_i),
    .confRegs_o (confRegs_o)
  );

  aipStatusReg statusReg (
    .clk          (clk),
    .rst          (rst),
    .hostCmd_i    (hostCmd_i),
    .coreStatus_i (coreStatus_i),
    .coreDone_i   (coreDone_i),
    .statusWord_o (statusWord),
    .irq_o        (irq_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tbCoreModel.sv ====
`default_nettype none

module tbCoreModel #(
  parameter int WordCount = 16
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     start_i,
  input  wire                     trap_i,
  input  wire aipBusPkg::word_t   memInData_i,
  output ipCorePkg::memRd_t       memRd_o,
  output ipCorePkg::memWr_t       memWr_o,
  output ipCorePkg::coreStatus_t  coreStatus_o,
  output logic                    done_o
);

  localparam aipBusPkg::word_t XorMask = 32'hA5A5_A5A5;

  logic busy;
  logic reading;
  logic writing;

  assign coreStatus_o = {busy, reading, writing, trap_i}; // Busy is the top field

  initial begin
    busy    = 1'b0;
    reading = 1'b0;
    writing = 1'b0;
    done_o  = 1'b0;
    memRd_o = '0;
    memWr_o = '0;
    forever begin
      @(posedge clk);
      if (rst && start_i) begin
        @(negedge clk);
        busy = 1'b1;
        for (int i = 0; i < WordCount; i++) begin
          reading      = 1'b1;
          writing      = 1'b0;
          memWr_o.wrEn = 1'b0;
          memRd_o.addr = ipCorePkg::memAddr_t'(i);
          @(negedge clk); // Read data registered on the edge in between
          reading      = 1'b0;
          writing      = 1'b1;
          memWr_o.wrEn = 1'b1;
          memWr_o.addr = ipCorePkg::memAddr_t'(i);
          memWr_o.data = memInData_i ^ XorMask;
          @(negedge clk);
        end
        memWr_o.wrEn = 1'b0;
        writing      = 1'b0;
        busy         = 1'b0;
        done_o       = 1'b1; // Single cycle done pulse
        @(negedge clk);
        done_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tbAipWrapper.sv ====
`default_nettype none

module tbAipWrapper;

  localparam int WordCount      = 16;
  localparam int ConfCount      = 4; // DUT default bank size
  localparam int HalfPeriod     = 4;
  localparam int SetupCycles    = 120;
  localparam int MarginCycles   = 100;
  localparam int WatchdogCycles = SetupCycles + 4 * WordCount + MarginCycles;

  localparam aipBusPkg::word_t ExpId     = 32'h0000_200F;
  localparam aipBusPkg::word_t XorMask   = 32'hA5A5_A5A5;
  localparam aipBusPkg::word_t IntEnMask = 32'h0000_0100;
  localparam aipBusPkg::word_t PendMask  = 32'h0001_0000;

  logic                             clk;
  logic                             rst;
  logic                             en;
  logic                             trapFlag;
  aipBusPkg::hostCmd_t              hostCmd;
  ipCorePkg::memRd_t                memRd;
  ipCorePkg::memWr_t                memWr;
  ipCorePkg::coreStatus_t           coreStatus;
  logic                             coreDone;
  aipBusPkg::word_t                 hostData;
  logic                             irq;
  logic                             start;
  aipBusPkg::word_t                 memInData;
  aipBusPkg::word_t [ConfCount-1:0] confRegs;

  integer           seed;
  int               errorCount;
  int               checkCount;
  aipBusPkg::word_t inWords [WordCount];
  aipBusPkg::word_t confModel [ConfCount];

  aipWrapper DUT (
    .clk          (clk),
    .rst          (rst),
    .en_i         (en),
    .hostCmd_i    (hostCmd),
    .memRd_i      (memRd),
    .memWr_i      (memWr),
    .coreStatus_i (coreStatus),
    .coreDone_i   (coreDone),
    .hostData_o   (hostData),
    .irq_o        (irq),
    .start_o      (start),
    .memInData_o  (memInData),
    .confRegs_o   (confRegs)
  );

  tbCoreModel #(.WordCount(WordCount)) coreModel (
    .clk          (clk),
    .rst          (rst),
    .start_i      (start),
    .trap_i       (trapFlag),
    .memInData_i  (memInData),
    .memRd_o      (memRd),
    .memWr_o      (memWr),
    .coreStatus_o (coreStatus),
    .done_o       (coreDone)
  );

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  task automatic checkWord(input aipBusPkg::word_t got, input aipBusPkg::word_t exp,
                           input string what);
    checkCount++;
    assert (got === exp) else begin
      errorCount++;
      $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // One strobe cycle followed by one idle cycle
  task automatic busCycle(input aipBusPkg::configCode_t code, input logic rd, input logic wr,
                          input logic st, input aipBusPkg::word_t data,
                          output aipBusPkg::word_t rdData);
    @(negedge clk);
    hostCmd.code  = code;
    hostCmd.read  = rd;
    hostCmd.write = wr;
    hostCmd.start = st;
    hostCmd.data  = data;
    #(HalfPeriod / 2);
    rdData = hostData; // Mid low phase
    @(negedge clk);
    hostCmd.read  = 1'b0;
    hostCmd.write = 1'b0;
    hostCmd.start = 1'b0;
  endtask

  task automatic hostWrite(input aipBusPkg::configCode_t code, input aipBusPkg::word_t data);
    aipBusPkg::word_t ignored;
    busCycle(code, 1'b0, 1'b1, 1'b0, data, ignored);
  endtask

  task automatic hostRead(input aipBusPkg::configCode_t code, output aipBusPkg::word_t data);
    busCycle(code, 1'b1, 1'b0, 1'b0, '0, data);
  endtask

  task automatic startCore();
    aipBusPkg::word_t ignored;
    busCycle(aipBusPkg::CfgId, 1'b0, 1'b0, 1'b1, '0, ignored);
  endtask

  initial begin
    aipBusPkg::word_t got;
    int               ptr;
    errorCount = 0;
    checkCount = 0;
    seed       = 32'hee48_8191;
    rst        = 1'b0;
    en         = 1'b1;
    trapFlag   = 1'b0;
    hostCmd    = '0;
    repeat (10) @(negedge clk);
    rst = 1'b1;

    hostRead(aipBusPkg::CfgId, got);
    checkWord(got, ExpId, "id word");
    hostRead(aipBusPkg::CfgStatus, got);
    checkWord(got, '0, "status after reset");
    checkWord({31'b0, irq}, '0, "irq after reset");

    // Step the pointer off register 0, then a load of ConfCount folds it back
    got = $random(seed);
    hostWrite(aipBusPkg::CfgConfData, got);
    hostWrite(aipBusPkg::CfgConfPtr, aipBusPkg::word_t'(ConfCount));
    ptr = 0;
    for (int i = 0; i <= ConfCount; i++) begin
      got = $random(seed);
      hostWrite(aipBusPkg::CfgConfData, got);
      confModel[ptr] = got;
      ptr = (ptr + 1) % ConfCount;
    end
    for (int i = 0; i < ConfCount; i++) begin
      checkWord(confRegs[i], confModel[i], $sformatf("config register %0d", i));
    end

    hostWrite(aipBusPkg::CfgMemInPtr, '0);
    for (int i = 0; i < WordCount; i++) begin
      inWords[i] = $random(seed);
      hostWrite(aipBusPkg::CfgMemInData, inWords[i]);
    end
    startCore();
    hostRead(aipBusPkg::CfgStatus, got);
    checkWord({31'b0, got[0]}, 32'd1, "busy flag while running");
    trapFlag = 1'b1;
    hostRead(aipBusPkg::CfgStatus, got);
    checkWord({31'b0, got[3]}, 32'd1, "trap flag");
    trapFlag = 1'b0;
    do begin
      hostRead(aipBusPkg::CfgStatus, got);
    end while (got[0]);

    // Done seen with interrupt disabled
    hostRead(aipBusPkg::CfgStatus, got);
    checkWord(got, PendMask, "status after done");
    checkWord({31'b0, irq}, '0, "irq with enable clear");
    hostWrite(aipBusPkg::CfgStatus, IntEnMask);
    checkWord({31'b0, irq}, 32'd1, "irq after enable");
    hostWrite(aipBusPkg::CfgStatus, IntEnMask | PendMask);
    checkWord({31'b0, irq}, '0, "irq after pending clear");
    hostRead(aipBusPkg::CfgStatus, got);
    checkWord(got, IntEnMask, "status after pending clear");

    hostWrite(aipBusPkg::CfgMemOutPtr, '0);
    for (int i = 0; i < WordCount; i++) begin
      hostRead(aipBusPkg::CfgMemOutData, got);
      checkWord(got, inWords[i] ^ XorMask, $sformatf("output word %0d", i));
    end

    hostWrite(aipBusPkg::CfgMemOutPtr, 32'd3);
    en = 1'b0;
    repeat (2) begin
      hostRead(aipBusPkg::CfgMemOutData, got);
      checkWord(got, inWords[3] ^ XorMask, "output word with pointer held");
    end
    en = 1'b1;

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Run timed out after %0d cycles with %0d errors", WatchdogCycles, errorCount);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/aipBusPkg.sv
verilog/ipCorePkg.sv
verilog/dualPortRam.sv
verilog/aipControl.sv
verilog/aipConfigRegs.sv
verilog/aipStatusReg.sv
verilog/aipWrapper.sv
testbench/tbCoreModel.sv
testbench/tbAipWrapper.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tbAipWrapper -o tbAipWrapper \
  && ./obj_dir/tbAipWrapper | tee /dev/stderr | grep -qx "SIMULATION PASSED" \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }
